// ==== design/shell_consts.svh ====
`ifndef SHELL_CONSTS_SVH
`define SHELL_CONSTS_SVH

// ----------------------------------------------------------------------
// host command format
// ----------------------------------------------------------------------

// byte address, word and id widths
`define SH_ADDR_W        16
`define SH_DATA_W        32
`define SH_ID_W          6

// ----------------------------------------------------------------------
// on-chip memory geometry
// ----------------------------------------------------------------------

// four 32-bit lanes, one per word slot in a 16-byte row
`define SH_NUM_BANKS     4
`define SH_LANE_W        2
`define SH_BANK_ROWS     16
`define SH_ROW_W         4

// byte address bit positions of lane and row
`define SH_LANE_LSB      2
`define SH_ROW_LSB       4

// bits at and above this position must be zero for a valid address
`define SH_MEM_ADDR_W    8

// command strobe to response strobe, in cycles
`define SH_RESP_LAT      3

`endif

// ==== design/shell_pkg.sv ====
`include "shell_consts.svh"

package shell_pkg;

   // ----------------------------------------------------------------------
   // encodings
   // ----------------------------------------------------------------------

   typedef enum logic {
      OP_POKE = 1'b0,
      OP_PEEK = 1'b1
   } sh_op_e;

   // axi response codes, exokay is never returned
   typedef enum logic [1:0] {
      RESP_OKAY   = 2'd0,
      RESP_SLVERR = 2'd2,
      RESP_DECERR = 2'd3
   } sh_resp_e;

   // lane bank sweep state
   typedef enum logic {
      BANK_INIT  = 1'b0,
      BANK_READY = 1'b1
   } bank_state_e;

   // ----------------------------------------------------------------------
   // grouped signals
   // ----------------------------------------------------------------------

   typedef struct packed {
      sh_op_e                  op;
      logic [`SH_ADDR_W-1:0]   addr;
      logic [`SH_DATA_W-1:0]   wdata;
      logic [`SH_ID_W-1:0]     id;
   } host_cmd_t;

   // broadcast to every lane, only the matching lane acts
   typedef struct packed {
      sh_op_e                  op;
      logic [`SH_ROW_W-1:0]    row;
      logic [`SH_LANE_W-1:0]   lane;
      logic [`SH_DATA_W-1:0]   wdata;
      logic                    en;
   } bank_req_t;

   // what the response stage needs to know about a command
   typedef struct packed {
      logic [`SH_ID_W-1:0]     id;
      sh_op_e                  op;
      logic [`SH_LANE_W-1:0]   lane;
      sh_resp_e                resp;
   } req_tag_t;

   typedef struct packed {
      logic [`SH_ID_W-1:0]     id;
      sh_resp_e                resp;
      logic [`SH_DATA_W-1:0]   rdata;
   } host_resp_t;

endpackage

// ==== design/host_cmd_unit.sv ====
`timescale 1ns/1ps
`include "shell_consts.svh"

module host_cmd_unit import shell_pkg::*; (
   input  logic       clk_out,
   input  logic       sync_rst_n,

   // host side
   input  logic       cmd_valid_i,
   input  host_cmd_t  cmd_i,
   input  logic       mem_ready_i,

   // to the lane banks
   output bank_req_t  bank_req_o,

   // to the response unit
   output logic       tag_valid_o,
   output req_tag_t   tag_o
);

   logic                    out_of_range;
   sh_resp_e                resp_d;
   logic                    accept;

   logic                    req_en_q;
   logic                    tag_vld_q;
   sh_op_e                  op_q;
   logic [`SH_ROW_W-1:0]    row_q;
   logic [`SH_LANE_W-1:0]   lane_q;
   logic [`SH_DATA_W-1:0]   wdata_q;
   logic [`SH_ID_W-1:0]     id_q;
   sh_resp_e                resp_q;

   // ----------------------------------------------------------------------
   // classification
   // ----------------------------------------------------------------------

   // anything above the 256-byte window decodes to nothing
   assign out_of_range = |cmd_i.addr[`SH_ADDR_W-1:`SH_MEM_ADDR_W];

   always_comb begin
      if (out_of_range) begin
         resp_d = RESP_DECERR;
      end else if (!mem_ready_i) begin
         resp_d = RESP_SLVERR;
      end else begin
         resp_d = RESP_OKAY;
      end
   end

   assign accept = cmd_valid_i && (resp_d == RESP_OKAY);

   // ----------------------------------------------------------------------
   // request and tag stage
   // ----------------------------------------------------------------------

   always_ff @(posedge clk_out or negedge sync_rst_n) begin
      if (!sync_rst_n) begin
         req_en_q  <= 1'b0;
         tag_vld_q <= 1'b0;
      end else begin
         req_en_q  <= accept;
         // rejected commands still get a response
         tag_vld_q <= cmd_valid_i;
      end
   end

   always_ff @(posedge clk_out) begin
      if (cmd_valid_i) begin
         op_q    <= cmd_i.op;
         row_q   <= cmd_i.addr[`SH_ROW_LSB +: `SH_ROW_W];
         lane_q  <= cmd_i.addr[`SH_LANE_LSB +: `SH_LANE_W];
         wdata_q <= cmd_i.wdata;
         id_q    <= cmd_i.id;
         resp_q  <= resp_d;
      end
   end

   assign bank_req_o = '{op: op_q, row: row_q, lane: lane_q, wdata: wdata_q, en: req_en_q};

   assign tag_valid_o = tag_vld_q;
   assign tag_o       = '{id: id_q, op: op_q, lane: lane_q, resp: resp_q};

endmodule

// ==== design/lane_bank.sv ====
`timescale 1ns/1ps
`include "shell_consts.svh"

module lane_bank import shell_pkg::*; #(
   parameter int BANK_IDX = 0
) (
   input  logic                    clk_out,
   input  logic                    sync_rst_n,

   // function-level reset restarts the clearing sweep
   input  logic                    flr_i,

   input  bank_req_t               bank_req_i,

   output logic [`SH_DATA_W-1:0]   rdata_o,
   output logic                    init_done_o
);

   localparam logic [`SH_LANE_W-1:0] MY_LANE  = `SH_LANE_W'(BANK_IDX);
   localparam logic [`SH_ROW_W-1:0]  LAST_ROW = `SH_ROW_W'(`SH_BANK_ROWS - 1);

   logic [`SH_DATA_W-1:0]   mem [`SH_BANK_ROWS];
   logic [`SH_DATA_W-1:0]   rdata_q;

   bank_state_e             state_q;
   logic [`SH_ROW_W-1:0]    init_row_q;
   logic                    hit;
   logic                    wr_en;

   // ----------------------------------------------------------------------
   // initialisation sweep
   // ----------------------------------------------------------------------

   // one row cleared per cycle, ready after the last one
   always_ff @(posedge clk_out or negedge sync_rst_n) begin
      if (!sync_rst_n) begin
         state_q    <= BANK_INIT;
         init_row_q <= '0;
      end else if (flr_i) begin
         state_q    <= BANK_INIT;
         init_row_q <= '0;
      end else if (state_q == BANK_INIT) begin
         init_row_q <= init_row_q + 1'b1;
         if (init_row_q == LAST_ROW) begin
            state_q <= BANK_READY;
         end
      end
   end

   assign init_done_o = (state_q == BANK_READY);

   // ----------------------------------------------------------------------
   // lane access
   // ----------------------------------------------------------------------

   assign hit = bank_req_i.en && (bank_req_i.lane == MY_LANE);

   // sweep owns the write port until it is done
   assign wr_en = hit && (bank_req_i.op == OP_POKE) && (state_q == BANK_READY);

   always_ff @(posedge clk_out) begin
      if (state_q == BANK_INIT) begin
         mem[init_row_q] <= '0;
      end else if (wr_en) begin
         mem[bank_req_i.row] <= bank_req_i.wdata;
      end
   end

   // old word on a poke, response stage drops it anyway
   always_ff @(posedge clk_out) begin
      if (hit) begin
         rdata_q <= mem[bank_req_i.row];
      end
   end

   assign rdata_o = rdata_q;

endmodule

// ==== design/resp_unit.sv ====
`timescale 1ns/1ps
`include "shell_consts.svh"

module resp_unit import shell_pkg::*; (
   input  logic                                       clk_out,
   input  logic                                       sync_rst_n,

   // from the command unit
   input  logic                                       tag_valid_i,
   input  req_tag_t                                   tag_i,

   // from the lane banks
   input  logic [`SH_NUM_BANKS-1:0][`SH_DATA_W-1:0]   bank_rdata_i,
   input  logic [`SH_NUM_BANKS-1:0]                   bank_init_done_i,

   output logic                                       mem_ready_o,
   output logic                                       resp_valid_o,
   output host_resp_t                                 resp_o
);

   // command stage and response stage take one cycle each
   localparam int TAG_STAGES = `SH_RESP_LAT - 2;

   logic [TAG_STAGES-1:0]   tag_vld_q;
   req_tag_t                tag_q [TAG_STAGES];

   logic                    al_vld;
   req_tag_t                al_tag;
   logic [`SH_DATA_W-1:0]   lane_word;
   logic [`SH_DATA_W-1:0]   rdata_d;

   logic                    resp_vld_q;
   host_resp_t              resp_q;

   // ----------------------------------------------------------------------
   // tag alignment with the bank read stage
   // ----------------------------------------------------------------------

   always_ff @(posedge clk_out or negedge sync_rst_n) begin
      if (!sync_rst_n) begin
         tag_vld_q <= '0;
      end else begin
         tag_vld_q[0] <= tag_valid_i;
         for (int s = 1; s < TAG_STAGES; s++) begin
            tag_vld_q[s] <= tag_vld_q[s-1];
         end
      end
   end

   always_ff @(posedge clk_out) begin
      tag_q[0] <= tag_i;
      for (int s = 1; s < TAG_STAGES; s++) begin
         tag_q[s] <= tag_q[s-1];
      end
   end

   assign al_vld = tag_vld_q[TAG_STAGES-1];
   assign al_tag = tag_q[TAG_STAGES-1];

   // ----------------------------------------------------------------------
   // response forming
   // ----------------------------------------------------------------------

   assign lane_word = bank_rdata_i[al_tag.lane];

   // only a good peek carries data
   always_comb begin
      if ((al_tag.op == OP_PEEK) && (al_tag.resp == RESP_OKAY)) begin
         rdata_d = lane_word;
      end else begin
         rdata_d = '0;
      end
   end

   always_ff @(posedge clk_out or negedge sync_rst_n) begin
      if (!sync_rst_n) begin
         resp_vld_q <= 1'b0;
      end else begin
         resp_vld_q <= al_vld;
      end
   end

   always_ff @(posedge clk_out) begin
      if (al_vld) begin
         resp_q <= '{id: al_tag.id, resp: al_tag.resp, rdata: rdata_d};
      end
   end

   assign resp_valid_o = resp_vld_q;
   assign resp_o       = resp_q;

   // memory is ready once every lane has finished its sweep
   assign mem_ready_o = &bank_init_done_i;

endmodule

// ==== design/shell_top.sv ====
`timescale 1ns/1ps
`include "shell_consts.svh"

module shell_top import shell_pkg::*; (
   input  logic        clk_out,
   input  logic        sync_rst_n,

   // host commands, one strobe per command
   input  logic        cmd_valid_i,
   input  host_cmd_t   cmd_i,

   // function-level reset strobe
   input  logic        flr_i,

   // responses, in command order
   output logic        resp_valid_o,
   output host_resp_t  resp_o,

   output logic        mem_ready_o
);

   bank_req_t                                 bank_req;
   logic                                      tag_valid;
   req_tag_t                                  tag;

   logic [`SH_NUM_BANKS-1:0][`SH_DATA_W-1:0]  bank_rdata;
   logic [`SH_NUM_BANKS-1:0]                  bank_init_done;

   // ----------------------------------------------------------------------
   // command decode
   // ----------------------------------------------------------------------

   host_cmd_unit u_host_cmd_unit (
      .clk_out     (clk_out),
      .sync_rst_n  (sync_rst_n),
      .cmd_valid_i (cmd_valid_i),
      .cmd_i       (cmd_i),
      .mem_ready_i (mem_ready_o),
      .bank_req_o  (bank_req),
      .tag_valid_o (tag_valid),
      .tag_o       (tag)
   );

   // ----------------------------------------------------------------------
   // lane banks
   // ----------------------------------------------------------------------

   // request goes to all lanes, each one checks the lane field
   for (genvar g = 0; g < `SH_NUM_BANKS; g++) begin : gen_bank
      lane_bank #(
         .BANK_IDX (g)
      ) u_lane_bank (
         .clk_out     (clk_out),
         .sync_rst_n  (sync_rst_n),
         .flr_i       (flr_i),
         .bank_req_i  (bank_req),
         .rdata_o     (bank_rdata[g]),
         .init_done_o (bank_init_done[g])
      );
   end

   // ----------------------------------------------------------------------
   // responses and memory ready
   // ----------------------------------------------------------------------

   resp_unit u_resp_unit (
      .clk_out          (clk_out),
      .sync_rst_n       (sync_rst_n),
      .tag_valid_i      (tag_valid),
      .tag_i            (tag),
      .bank_rdata_i     (bank_rdata),
      .bank_init_done_i (bank_init_done),
      .mem_ready_o      (mem_ready_o),
      .resp_valid_o     (resp_valid_o),
      .resp_o           (resp_o)
   );

endmodule

// ==== testbench/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen #(
   parameter int HALF_PERIOD = 50,
   parameter int RST_CYCLES  = 16,
   parameter int RST_DLY     = 10
) (
   output logic clk_out_o,
   output logic sync_rst_n_o
);

   initial begin
      clk_out_o = 1'b0;
      forever begin
         #HALF_PERIOD clk_out_o = ~clk_out_o;
      end
   end

   // release a little after an edge, same as the other inputs
   initial begin
      sync_rst_n_o = 1'b0;
      repeat (RST_CYCLES) @(posedge clk_out_o);
      #RST_DLY sync_rst_n_o = 1'b1;
   end

endmodule

// ==== testbench/tb_shell.sv ====
`timescale 1ns/1ps
`include "shell_consts.svh"

module tb_shell import shell_pkg::*; ();

   localparam int DRIVE_DLY   = 10;
   localparam int NUM_WORDS   = `SH_NUM_BANKS * `SH_BANK_ROWS;
   localparam int TEST_CYCLES = 16 + 2 * (`SH_BANK_ROWS + `SH_RESP_LAT) + 1300;
   localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

   logic        clk_out;
   logic        sync_rst_n;
   logic        cmd_valid_i;
   host_cmd_t   cmd_i;
   logic        flr_i;
   logic        resp_valid_o;
   host_resp_t  resp_o;
   logic        mem_ready_o;

   // reference model state
   logic [`SH_DATA_W-1:0]  model_mem [NUM_WORDS];
   host_resp_t             exp_q [$];
   int                     due_q [$];
   int                     cycle;
   int                     ready_at;
   int                     err_cnt;
   integer                 seed;

   clk_gen u_clk_gen (
      .clk_out_o    (clk_out),
      .sync_rst_n_o (sync_rst_n)
   );

   shell_top u_shell_top (
      .clk_out      (clk_out),
      .sync_rst_n   (sync_rst_n),
      .cmd_valid_i  (cmd_valid_i),
      .cmd_i        (cmd_i),
      .flr_i        (flr_i),
      .resp_valid_o (resp_valid_o),
      .resp_o       (resp_o),
      .mem_ready_o  (mem_ready_o)
   );

   // ----------------------------------------------------------------------
   // checking
   // ----------------------------------------------------------------------

   task automatic value_error(input string what, input logic [31:0] exp,
                              input logic [31:0] got);
      $display("FAIL at %0t ns: %s expected %0h got %0h", $time, what, exp, got);
      err_cnt = err_cnt + 1;
      $display("tests failed");
      $fatal(1, "stopped at the first mismatch");
   endtask

   // outputs seen here belong to the edge just passed
   task automatic check_outputs();
      host_resp_t exp;
      logic       exp_ready;
      exp_ready = (cycle >= ready_at);
      assert (mem_ready_o === exp_ready)
         else value_error("mem_ready_o", exp_ready, mem_ready_o);
      if ((due_q.size() > 0) && (due_q[0] == cycle)) begin
         exp = exp_q.pop_front();
         due_q.delete(0);
         assert (resp_valid_o === 1'b1)
            else value_error("resp_valid_o", 1, resp_valid_o);
         assert (resp_o.id === exp.id)
            else value_error("resp id", exp.id, resp_o.id);
         assert (resp_o.resp === exp.resp)
            else value_error("resp code", exp.resp, resp_o.resp);
         assert (resp_o.rdata === exp.rdata)
            else value_error("resp rdata", exp.rdata, resp_o.rdata);
      end else begin
         assert (resp_valid_o === 1'b0)
            else value_error("resp_valid_o", 0, resp_valid_o);
      end
   endtask

   // ----------------------------------------------------------------------
   // stimulus
   // ----------------------------------------------------------------------

   task automatic next_cycle();
      @(posedge clk_out);
      #DRIVE_DLY;
      cycle = cycle + 1;
      check_outputs();
      cmd_valid_i = 1'b0;
      flr_i       = 1'b0;
   endtask

   // strobe one command and queue what the host should get back
   task automatic send_cmd(input sh_op_e op, input logic [`SH_ADDR_W-1:0] addr,
                           input logic [`SH_DATA_W-1:0] wdata,
                           input logic [`SH_ID_W-1:0] id);
      host_resp_t  exp;
      int          idx;
      next_cycle();
      cmd_valid_i = 1'b1;
      cmd_i.op    = op;
      cmd_i.addr  = addr;
      cmd_i.wdata = wdata;
      cmd_i.id    = id;
      exp.id    = id;
      exp.rdata = '0;
      if (addr[`SH_ADDR_W-1:`SH_MEM_ADDR_W] != '0) begin
         exp.resp = RESP_DECERR;
      end else if (cycle < ready_at) begin
         exp.resp = RESP_SLVERR;
      end else begin
         exp.resp = RESP_OKAY;
      end
      // word index, byte offset bits dropped
      idx = addr[`SH_MEM_ADDR_W-1:2];
      if (exp.resp == RESP_OKAY) begin
         if (op == OP_POKE) begin
            model_mem[idx] = wdata;
         end else begin
            exp.rdata = model_mem[idx];
         end
      end
      exp_q.push_back(exp);
      due_q.push_back(cycle + `SH_RESP_LAT);
   endtask

   task automatic drain();
      while (exp_q.size() > 0) begin
         next_cycle();
      end
   endtask

   task automatic wait_ready();
      while (mem_ready_o !== 1'b1) begin
         next_cycle();
      end
   endtask

   task automatic peek_all();
      for (int i = 0; i < NUM_WORDS; i++) begin
         send_cmd(OP_PEEK, `SH_ADDR_W'(i * 4), $random(seed), $random(seed));
      end
      drain();
   endtask

   task automatic pulse_flr();
      next_cycle();
      flr_i    = 1'b1;
      // banks go busy at the sampling edge and sweep every row
      ready_at = cycle + 1 + `SH_BANK_ROWS;
      for (int i = 0; i < NUM_WORDS; i++) begin
         model_mem[i] = '0;
      end
   endtask

   // ----------------------------------------------------------------------
   // watchdog
   // ----------------------------------------------------------------------

   initial begin : watchdog
      int unsigned cyc_cnt;
      cyc_cnt = 0;
      while (cyc_cnt < CYCLE_LIMIT) begin
         @(posedge clk_out);
         cyc_cnt = cyc_cnt + 1;
      end
      $display("timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
      $display("tests failed");
      $fatal(1, "timeout");
   end

   // ----------------------------------------------------------------------
   // test sequence
   // ----------------------------------------------------------------------

   initial begin : main
      logic [31:0]             rnd;
      logic [7:0]              hi;
      logic [`SH_ADDR_W-1:0]   addr;
      logic [7:0]              saved [32];

      seed        = 32'h9b2e;
      err_cnt     = 0;
      cycle       = 0;
      ready_at    = `SH_BANK_ROWS;
      cmd_valid_i = 1'b0;
      cmd_i       = '0;
      flr_i       = 1'b0;
      for (int i = 0; i < NUM_WORDS; i++) begin
         model_mem[i] = '0;
      end

      @(posedge sync_rst_n);
      cycle = 0;

      // initial state, everything cleared by the sweep
      wait_ready();
      peek_all();

      // poke then peek the same addresses
      for (int i = 0; i < 32; i++) begin
         rnd      = $random(seed);
         saved[i] = rnd[7:0];
         send_cmd(OP_POKE, {8'h00, saved[i]}, $random(seed), rnd[29:24]);
      end
      for (int i = 0; i < 32; i++) begin
         send_cmd(OP_PEEK, {8'h00, saved[i]}, $random(seed), $random(seed));
      end
      drain();

      // out of range, pokes must not land anywhere
      for (int i = 0; i < 16; i++) begin
         rnd = $random(seed);
         hi  = rnd[15:8];
         if (hi == 8'h00) begin
            hi = 8'h01;
         end
         saved[i] = rnd[7:0];
         send_cmd(sh_op_e'(rnd[16]), {hi, rnd[7:0]}, $random(seed), rnd[29:24]);
      end
      for (int i = 0; i < 16; i++) begin
         send_cmd(OP_PEEK, {8'h00, saved[i]}, $random(seed), $random(seed));
      end
      drain();

      // function-level reset, then commands during the sweep
      pulse_flr();
      next_cycle();
      send_cmd(OP_POKE, 16'h0010, $random(seed), $random(seed));
      send_cmd(OP_PEEK, 16'h0010, $random(seed), $random(seed));
      drain();
      wait_ready();
      peek_all();

      // back-to-back mixed traffic, about one in eight out of range
      for (int i = 0; i < 1000; i++) begin
         rnd  = $random(seed);
         addr = {8'h00, rnd[7:0]};
         if (rnd[10:8] == 3'b000) begin
            addr[15:8] = rnd[23:16] | 8'h01;
         end
         send_cmd(sh_op_e'(rnd[11]), addr, $random(seed), rnd[29:24]);
      end
      drain();
      next_cycle();

      if (err_cnt == 0) begin
         $display("all tests passed");
         $finish;
      end else begin
         $display("tests failed");
         $fatal(1, "checks failed");
      end
   end

endmodule

// ==== verilog.f ====
+incdir+design
design/shell_pkg.sv
design/host_cmd_unit.sv
design/lane_bank.sv
design/resp_unit.sv
design/shell_top.sv
testbench/clk_gen.sv
testbench/tb_shell.sv
